// ==== src/procPkg.sv ====
// word-addressed instruction and data space; opcode in bits 15..12, codes not listed are illegal
`default_nettype none

package procPkg;

   // data words and addresses share one width
   localparam int dataWidth = 16;
   // eight registers, r0 is an ordinary register
   localparam int regAddrWidth = 3;
   localparam int numRegs = 2 ** regAddrWidth;

   // instruction memory size in words
   localparam int imemDepth = 256;
   localparam int imemAddrWidth = $clog2(imemDepth);

   // first fetch address and pc increment
   localparam logic [dataWidth-1:0] resetPc = '0;
   localparam logic [dataWidth-1:0] pcStep = 1;

   // instruction fields
   localparam int opcodeWidth = 4;
   localparam int opMsb = 15;
   localparam int opLsb = 12;
   // rd, also the BEQZ source and the ST data register
   localparam int rdMsb = 11;
   localparam int rdLsb = 9;
   localparam int rsMsb = 8;
   localparam int rsLsb = 6;
   localparam int rtMsb = 5;
   localparam int rtLsb = 3;
   // signed immediate widths for I format, BEQZ and J
   localparam int immIWidth = 6;
   localparam int immBWidth = 9;
   localparam int immJWidth = 12;

   typedef enum logic [opcodeWidth-1:0] {
      ADD  = 4'h0,
      SUB  = 4'h1,
      AND  = 4'h2,
      XOR  = 4'h3,
      ADDI = 4'h4,
      LD   = 4'h5,
      ST   = 4'h6,
      BEQZ = 4'h7,
      J    = 4'h8,
      HALT = 4'hf
   } opcodeT;

   // data memory handshake states
   typedef enum logic [1:0] {
      stIdle,
      stRequest,
      stRelease
   } memStateT;

endpackage

`default_nettype wire

// ==== src/fetch.sv ====
// program.hex is read at time zero; pc wraps inside imemDepth words; stays stopped after HALT until reset
`timescale 1ns/1ps
`default_nettype none

module fetch (
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          memBusy,
   input  logic                          hazardStall,
   input  logic                          stopFetch,
   input  logic                          redirect,
   input  logic [procPkg::dataWidth-1:0] redirectPc,
   output logic [procPkg::dataWidth-1:0] instrD,
   output logic [procPkg::dataWidth-1:0] pcNextD,
   output logic                          validD
);

   logic [procPkg::dataWidth-1:0] pc;
   logic [procPkg::dataWidth-1:0] pcPlusOne;
   // set once a HALT or illegal word has been handed to decode
   logic                          stopped;
   // read-only program store
   logic [procPkg::dataWidth-1:0] imem [procPkg::imemDepth];

   initial begin
      $readmemh("program.hex", imem);
   end

   assign pcPlusOne = pc + procPkg::pcStep;

   // pc and valid bit
   always_ff @(posedge clk) begin
      if (rst) begin
         pc      <= procPkg::resetPc;
         validD  <= 1'b0;
         stopped <= 1'b0;
      end else if (!memBusy) begin
         if (redirect) begin
            // branch or jump in execute wins, younger word is dropped
            pc     <= redirectPc;
            validD <= 1'b0;
         end else if (!hazardStall) begin
            if (stopFetch || stopped) begin
               stopped <= 1'b1;
               validD  <= 1'b0;
            end else begin
               pc     <= pcPlusOne;
               validD <= 1'b1;
            end
         end
      end
   end

   // instruction and next pc toward decode
   always_ff @(posedge clk) begin
      if (!memBusy && !redirect && !hazardStall) begin
         instrD  <= imem[pc[procPkg::imemAddrWidth-1:0]];
         pcNextD <= pcPlusOne;
      end
   end

endmodule

`default_nettype wire

// ==== src/decode.sv ====
// no forwarding: a source matching a live write in execute or memory stalls; registers read zero after reset
`timescale 1ns/1ps
`default_nettype none

module decode (
   input  logic                             clk,
   input  logic                             rst,
   input  logic                             memBusy,
   input  logic                             redirect,
   input  logic [procPkg::dataWidth-1:0]    instrD,
   input  logic [procPkg::dataWidth-1:0]    pcNextD,
   input  logic                             validD,
   input  logic [procPkg::regAddrWidth-1:0] exDest,
   input  logic                             exWrites,
   input  logic [procPkg::regAddrWidth-1:0] memDest,
   input  logic                             memWrites,
   input  logic                             wbEn,
   input  logic [procPkg::regAddrWidth-1:0] wbReg,
   input  logic [procPkg::dataWidth-1:0]    wbData,
   output logic                             hazardStall,
   output logic                             stopFetch,
   output procPkg::opcodeT                  opE,
   output logic [procPkg::dataWidth-1:0]    rsValE,
   output logic [procPkg::dataWidth-1:0]    rtValE,
   output logic [procPkg::dataWidth-1:0]    immE,
   output logic [procPkg::dataWidth-1:0]    pcNextE,
   output logic [procPkg::regAddrWidth-1:0] destE,
   output logic                             writesE,
   output logic                             validE
);

   procPkg::opcodeT                  op;
   logic [procPkg::regAddrWidth-1:0] srcA;
   logic [procPkg::regAddrWidth-1:0] srcB;
   logic [procPkg::regAddrWidth-1:0] dest;
   logic                             useA;
   logic                             useB;
   logic                             writes;
   logic                             stop;
   logic                             hazA;
   logic                             hazB;
   logic [procPkg::dataWidth-1:0]    immI;
   logic [procPkg::dataWidth-1:0]    immB;
   logic [procPkg::dataWidth-1:0]    immJ;
   logic [procPkg::dataWidth-1:0]    imm;
   logic [procPkg::dataWidth-1:0]    valA;
   logic [procPkg::dataWidth-1:0]    valB;
   logic [procPkg::dataWidth-1:0]    regs [procPkg::numRegs];

   // illegal codes pass through unchanged
   assign op = procPkg::opcodeT'(instrD[procPkg::opMsb:procPkg::opLsb]);
   assign dest = instrD[procPkg::rdMsb:procPkg::rdLsb];

   // BEQZ tests the register in the rd slot
   assign srcA = (op == procPkg::BEQZ) ? instrD[procPkg::rdMsb:procPkg::rdLsb]
                                       : instrD[procPkg::rsMsb:procPkg::rsLsb];
   // ST takes its data from the rd slot
   assign srcB = (op == procPkg::ST) ? instrD[procPkg::rdMsb:procPkg::rdLsb]
                                     : instrD[procPkg::rtMsb:procPkg::rtLsb];

   // sign extension per format
   assign immI = {{(procPkg::dataWidth-procPkg::immIWidth){instrD[procPkg::immIWidth-1]}},
                  instrD[procPkg::immIWidth-1:0]};
   assign immB = {{(procPkg::dataWidth-procPkg::immBWidth){instrD[procPkg::immBWidth-1]}},
                  instrD[procPkg::immBWidth-1:0]};
   assign immJ = {{(procPkg::dataWidth-procPkg::immJWidth){instrD[procPkg::immJWidth-1]}},
                  instrD[procPkg::immJWidth-1:0]};

   // control decode
   always_comb begin
      useA   = 1'b0;
      useB   = 1'b0;
      writes = 1'b0;
      stop   = 1'b0;
      imm    = immI;
      case (op)
         procPkg::ADD, procPkg::SUB, procPkg::AND, procPkg::XOR: begin
            useA   = 1'b1;
            useB   = 1'b1;
            writes = 1'b1;
         end
         procPkg::ADDI, procPkg::LD: begin
            useA   = 1'b1;
            writes = 1'b1;
         end
         procPkg::ST: begin
            useA = 1'b1;
            useB = 1'b1;
         end
         procPkg::BEQZ: begin
            useA = 1'b1;
            imm  = immB;
         end
         procPkg::J: imm = immJ;
         procPkg::HALT: stop = 1'b1;
         // illegal opcode stops fetch like HALT
         default: stop = 1'b1;
      endcase
   end

   // register file, written in writeback
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < procPkg::numRegs; i++) begin
            regs[i] <= '0;
         end
      end else if (wbEn) begin
         regs[wbReg] <= wbData;
      end
   end

   // write-through so writeback is seen this cycle
   assign valA = (wbEn && wbReg == srcA) ? wbData : regs[srcA];
   assign valB = (wbEn && wbReg == srcB) ? wbData : regs[srcB];

   // compare sources against writes still in flight
   assign hazA = useA && ((exWrites && exDest == srcA) || (memWrites && memDest == srcA));
   assign hazB = useB && ((exWrites && exDest == srcB) || (memWrites && memDest == srcB));
   assign hazardStall = validD && (hazA || hazB);
   assign stopFetch = validD && stop;

   // bubble into execute on stall or flush
   always_ff @(posedge clk) begin
      if (rst) begin
         validE <= 1'b0;
      end else if (!memBusy) begin
         validE <= validD && !hazardStall && !redirect;
      end
   end

   always_ff @(posedge clk) begin
      if (!memBusy) begin
         opE     <= op;
         rsValE  <= valA;
         rtValE  <= valB;
         immE    <= imm;
         pcNextE <= pcNextD;
         destE   <= dest;
         writesE <= writes;
      end
   end

endmodule

`default_nettype wire

// ==== src/execute.sv ====
// branch and jump targets are next pc plus offset; redirect lasts one cycle unless memory stalls
`timescale 1ns/1ps
`default_nettype none

module execute (
   input  logic                             clk,
   input  logic                             rst,
   input  logic                             memBusy,
   input  procPkg::opcodeT                  opE,
   input  logic [procPkg::dataWidth-1:0]    rsValE,
   input  logic [procPkg::dataWidth-1:0]    rtValE,
   input  logic [procPkg::dataWidth-1:0]    immE,
   input  logic [procPkg::dataWidth-1:0]    pcNextE,
   input  logic [procPkg::regAddrWidth-1:0] destE,
   input  logic                             writesE,
   input  logic                             validE,
   output logic                             redirect,
   output logic [procPkg::dataWidth-1:0]    redirectPc,
   output logic [procPkg::regAddrWidth-1:0] exDest,
   output logic                             exWrites,
   output procPkg::opcodeT                  opM,
   output logic [procPkg::dataWidth-1:0]    resultM,
   output logic [procPkg::dataWidth-1:0]    storeDataM,
   output logic [procPkg::regAddrWidth-1:0] destM,
   output logic                             writesM,
   output logic                             validM
);

   logic [procPkg::dataWidth-1:0] aluOut;
   logic                          taken;

   // alu, address adder and branch test
   always_comb begin
      aluOut = '0;
      taken  = 1'b0;
      case (opE)
         procPkg::ADD: aluOut = rsValE + rtValE;
         procPkg::SUB: aluOut = rsValE - rtValE;
         procPkg::AND: aluOut = rsValE & rtValE;
         procPkg::XOR: aluOut = rsValE ^ rtValE;
         // ADDI result or LD/ST address
         procPkg::ADDI, procPkg::LD, procPkg::ST: aluOut = rsValE + immE;
         procPkg::BEQZ: taken = (rsValE == '0);
         procPkg::J: taken = 1'b1;
         // HALT and illegal codes carry no result
         default: aluOut = '0;
      endcase
   end

   assign redirect = validE && taken;
   assign redirectPc = pcNextE + immE;

   // destination back to decode for hazard checks
   assign exDest = destE;
   assign exWrites = validE && writesE;

   // execute-to-memory register
   always_ff @(posedge clk) begin
      if (rst) begin
         validM <= 1'b0;
      end else if (!memBusy) begin
         validM <= validE;
      end
   end

   always_ff @(posedge clk) begin
      if (!memBusy) begin
         opM        <= opE;
         resultM    <= aluOut;
         storeDataM <= rtValE;
         destM      <= destE;
         writesM    <= writesE;
      end
   end

endmodule

`default_nettype wire

// ==== src/memAccess.sv ====
// four-phase req/ack master; whole pipeline waits until memReq and memAck are both low again
`timescale 1ns/1ps
`default_nettype none

module memAccess (
   input  logic                             clk,
   input  logic                             rst,
   input  procPkg::opcodeT                  opM,
   input  logic [procPkg::dataWidth-1:0]    resultM,
   input  logic [procPkg::dataWidth-1:0]    storeDataM,
   input  logic [procPkg::regAddrWidth-1:0] destM,
   input  logic                             writesM,
   input  logic                             validM,
   input  logic                             memAck,
   input  logic [procPkg::dataWidth-1:0]    memRData,
   output logic                             memBusy,
   output logic                             memReq,
   output logic                             memWe,
   output logic [procPkg::dataWidth-1:0]    memAddr,
   output logic [procPkg::dataWidth-1:0]    memWData,
   output logic [procPkg::regAddrWidth-1:0] memDest,
   output logic                             memWrites,
   output logic                             wbEn,
   output logic [procPkg::regAddrWidth-1:0] wbReg,
   output logic [procPkg::dataWidth-1:0]    wbData,
   output logic                             halt,
   output logic                             err
);

   procPkg::memStateT             state;
   logic                          isMem;
   logic                          isIllegal;
   logic [procPkg::dataWidth-1:0] loadData;

   always_comb begin
      isMem     = 1'b0;
      isIllegal = 1'b0;
      case (opM)
         procPkg::LD, procPkg::ST: isMem = 1'b1;
         procPkg::ADD, procPkg::SUB, procPkg::AND, procPkg::XOR, procPkg::ADDI,
         procPkg::BEQZ, procPkg::J, procPkg::HALT: isMem = 1'b0;
         default: isIllegal = 1'b1;
      endcase
   end

   // bus outputs come straight from the held memory register
   assign memReq = (state == procPkg::stRequest);
   assign memWe = memReq && (opM == procPkg::ST);
   assign memAddr = resultM;
   assign memWData = storeDataM;

   // busy from the first cycle of LD/ST until ack has dropped
   assign memBusy = (state == procPkg::stIdle && validM && isMem) ||
                    (state == procPkg::stRequest) ||
                    (state == procPkg::stRelease && memAck);

   assign memDest = destM;
   assign memWrites = validM && writesM;

   // handshake FSM
   always_ff @(posedge clk) begin
      if (rst) begin
         state <= procPkg::stIdle;
      end else begin
         case (state)
            procPkg::stIdle: if (validM && isMem) state <= procPkg::stRequest;
            procPkg::stRequest: if (memAck) state <= procPkg::stRelease;
            procPkg::stRelease: if (!memAck) state <= procPkg::stIdle;
            default: state <= procPkg::stIdle;
         endcase
      end
   end

   // read data is valid while ack is high
   always_ff @(posedge clk) begin
      if (state == procPkg::stRequest && memAck) begin
         loadData <= memRData;
      end
   end

   // memory-to-writeback register and sticky stop flags
   always_ff @(posedge clk) begin
      if (rst) begin
         wbEn <= 1'b0;
         halt <= 1'b0;
         err  <= 1'b0;
      end else if (!memBusy) begin
         wbEn <= validM && writesM;
         halt <= halt || (validM && (opM == procPkg::HALT || isIllegal));
         err  <= err || (validM && isIllegal);
      end
   end

   // writeback select
   always_ff @(posedge clk) begin
      if (!memBusy) begin
         wbReg  <= destM;
         wbData <= (opM == procPkg::LD) ? loadData : resultM;
      end
   end

endmodule

`default_nettype wire

// ==== src/proc.sv ====
// top level; data memory must follow the four-phase req/ack rules, instruction memory is internal
`timescale 1ns/1ps
`default_nettype none

module proc (
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          memAck,
   input  logic [procPkg::dataWidth-1:0] memRData,
   output logic                          memReq,
   output logic                          memWe,
   output logic [procPkg::dataWidth-1:0] memAddr,
   output logic [procPkg::dataWidth-1:0] memWData,
   output logic                          halt,
   output logic                          err
);

   // fetch to decode
   logic [procPkg::dataWidth-1:0]    instrD;
   logic [procPkg::dataWidth-1:0]    pcNextD;
   logic                             validD;
   // decode to execute
   procPkg::opcodeT                  opE;
   logic [procPkg::dataWidth-1:0]    rsValE;
   logic [procPkg::dataWidth-1:0]    rtValE;
   logic [procPkg::dataWidth-1:0]    immE;
   logic [procPkg::dataWidth-1:0]    pcNextE;
   logic [procPkg::regAddrWidth-1:0] destE;
   logic                             writesE;
   logic                             validE;
   // execute to memory
   procPkg::opcodeT                  opM;
   logic [procPkg::dataWidth-1:0]    resultM;
   logic [procPkg::dataWidth-1:0]    storeDataM;
   logic [procPkg::regAddrWidth-1:0] destM;
   logic                             writesM;
   logic                             validM;
   // stalls, flushes and hazard feedback
   logic                             memBusy;
   logic                             hazardStall;
   logic                             stopFetch;
   logic                             redirect;
   logic [procPkg::dataWidth-1:0]    redirectPc;
   logic [procPkg::regAddrWidth-1:0] exDest;
   logic                             exWrites;
   logic [procPkg::regAddrWidth-1:0] memDest;
   logic                             memWrites;
   // writeback into the register file
   logic                             wbEn;
   logic [procPkg::regAddrWidth-1:0] wbReg;
   logic [procPkg::dataWidth-1:0]    wbData;

   fetch uFetch (
      .clk, .rst, .memBusy, .hazardStall, .stopFetch, .redirect, .redirectPc,
      .instrD, .pcNextD, .validD
   );

   decode uDecode (
      .clk, .rst, .memBusy, .redirect, .instrD, .pcNextD, .validD,
      .exDest, .exWrites, .memDest, .memWrites, .wbEn, .wbReg, .wbData,
      .hazardStall, .stopFetch, .opE, .rsValE, .rtValE, .immE, .pcNextE,
      .destE, .writesE, .validE
   );

   execute uExecute (
      .clk, .rst, .memBusy, .opE, .rsValE, .rtValE, .immE, .pcNextE, .destE,
      .writesE, .validE, .redirect, .redirectPc, .exDest, .exWrites,
      .opM, .resultM, .storeDataM, .destM, .writesM, .validM
   );

   // memory stage also holds the writeback select
   memAccess uMemAccess (
      .clk, .rst, .opM, .resultM, .storeDataM, .destM, .writesM, .validM,
      .memAck, .memRData, .memBusy, .memReq, .memWe, .memAddr, .memWData,
      .memDest, .memWrites, .wbEn, .wbReg, .wbData, .halt, .err
   );

endmodule

`default_nettype wire

// ==== testbench/procTb.sv ====
// must run from testbench/ so fetch finds program.hex; the expected stores assume that program
`timescale 1ns/1ps
`default_nettype none

module procTb;

   logic        clk = 1'b0;
   logic        rst = 1'b1;
   logic        memAck = 1'b0;
   logic [15:0] memRData = 16'h0;
   logic        memReq;
   logic        memWe;
   logic [15:0] memAddr;
   logic [15:0] memWData;
   logic        halt;
   logic        err;

   // data memory model
   logic [15:0] dataMem [65536];
   logic [15:0] logAddr [$];
   logic [15:0] logData [$];
   logic [15:0] expAddr [$];
   logic [15:0] expData [$];
   logic [31:0] rngState = 32'hd730beb1;
   bit          pending = 1'b0;
   int          delayLeft = 0;

   // per-test and overall counts
   int testNum = 1;
   int testErrors = 0;
   int passCount = 0;
   int failCount = 0;
   bit haltSeen = 1'b0;

   proc i_proc (
      .clk, .rst, .memAck, .memRData, .memReq, .memWe, .memAddr, .memWData, .halt, .err
   );

   always #5 clk = ~clk;

   function automatic logic [31:0] xorshiftStep(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // preload pattern, every address bit matters
   function automatic logic [15:0] fillWord(input logic [15:0] addr);
      return {addr[7:0], addr[15:8]} ^ 16'ha55a;
   endfunction

   function automatic void expectStore(input logic [15:0] addr, input logic [15:0] data);
      expAddr.push_back(addr);
      expData.push_back(data);
   endfunction

   initial begin
      for (int a = 0; a < 65536; a++) begin
         dataMem[a] = fillWord(16'(a));
      end
   end

   // four-phase slave, ack after 0 to 5 idle cycles
   always @(posedge clk) begin
      if (rst) begin
         memAck <= 1'b0;
         pending = 1'b0;
      end else if (memReq && !memAck) begin
         if (!pending) begin
            pending = 1'b1;
            rngState = xorshiftStep(rngState);
            delayLeft = int'(rngState % 32'd6);
         end
         if (delayLeft == 0) begin
            pending = 1'b0;
            memAck <= 1'b1;
            if (memWe) begin
               dataMem[memAddr] <= memWData;
               logAddr.push_back(memAddr);
               logData.push_back(memWData);
            end else begin
               memRData <= dataMem[memAddr];
            end
         end else begin
            delayLeft--;
         end
      end else if (!memReq && memAck) begin
         // req has dropped, finish the transfer
         memAck <= 1'b0;
      end
   end

   task automatic compareValue(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
      assert (got === exp) else begin
         $display("FAIL %s: got %h expected %h", name, got, exp);
         testErrors++;
      end
   endtask

   task automatic confirm(input bit cond, input string what);
      assert (cond) else begin
         $display("ERROR %s", what);
         testErrors++;
      end
   endtask

   task automatic reportTest(input string name);
      if (testErrors == 0) begin
         passCount++;
         $display("test %0d %s: ok", testNum, name);
      end else begin
         failCount++;
         $display("test %0d %s: %0d errors", testNum, name, testErrors);
      end
      testNum++;
      testErrors = 0;
   endtask

   // called at time zero or on a rising edge; rst is seen on two edges
   task automatic applyReset;
      rst <= 1'b1;
      @(posedge clk);
      @(negedge clk);
      compareValue("memReq", 16'(memReq), 16'h0);
      compareValue("halt", 16'(halt), 16'h0);
      compareValue("err", 16'(err), 16'h0);
      @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      compareValue("memReq", 16'(memReq), 16'h0);
      compareValue("halt", 16'(halt), 16'h0);
      compareValue("err", 16'(err), 16'h0);
   endtask

   task automatic waitForHalt(input int limit);
      haltSeen = 1'b0;
      for (int n = 0; n < limit && !haltSeen; n++) begin
         @(negedge clk);
         haltSeen = halt;
      end
   endtask

   task automatic compareStores(input int first, input int last);
      for (int i = first; i < last; i++) begin
         if (i < logAddr.size()) begin
            compareValue($sformatf("memAddr of store %0d", i), logAddr[i], expAddr[i]);
            compareValue($sformatf("memWData of store %0d", i), logData[i], expData[i]);
         end else begin
            confirm(1'b0, $sformatf("store %0d was never made", i));
         end
      end
   endtask

   initial begin
      logic [15:0] a;
      logic [15:0] b;
      bit          stray;
      bit          reqAfterHalt;
      // r1 and r2 as set by the two ADDI at the top
      a = 16'd5;
      b = 16'd3;
      expectStore(16'd16, a + b);
      expectStore(16'd17, a - b);
      expectStore(16'd18, a & b);
      expectStore(16'd19, a ^ b);
      // r7 = r0 + sign-extended -2
      expectStore(16'd20, 16'hfffe);
      // loaded word plus r1
      expectStore(16'd21, fillWord(16'd8) + a);
      // taken branch skips 22, the not-taken one falls through to r2
      expectStore(16'd23, b);
      // jump skips 24 and lands on the r6 store
      expectStore(16'd25, a ^ b);

      applyReset();
      @(posedge clk);
      @(negedge clk);
      compareValue("memReq", 16'(memReq), 16'h0);
      compareValue("halt", 16'(halt), 16'h0);
      compareValue("err", 16'(err), 16'h0);
      reportTest("reset");

      waitForHalt(2000);
      compareStores(0, 5);
      reportTest("arithmetic");
      compareStores(5, 6);
      reportTest("load-use");

      stray = 1'b0;
      foreach (logAddr[i]) begin
         if (logAddr[i] == 16'd22 || logAddr[i] == 16'd24) begin
            stray = 1'b1;
         end
      end
      confirm(!stray, "a store on a skipped path was made");
      compareValue("store count", 16'(logAddr.size()), 16'(expAddr.size()));
      compareStores(6, expAddr.size());
      reportTest("control flow");

      confirm(haltSeen, "halt did not rise within 2000 cycles");
      reqAfterHalt = 1'b0;
      for (int n = 0; n < 50; n++) begin
         @(negedge clk);
         if (memReq) begin
            reqAfterHalt = 1'b1;
         end
      end
      confirm(!reqAfterHalt, "memReq rose after halt");
      compareValue("halt", 16'(halt), 16'h1);
      compareValue("err", 16'(err), 16'h0);
      reportTest("halt");

      // word 7 follows the first store, opcode 9 is not defined
      i_proc.uFetch.imem[7] = {4'h9, 12'h000};
      logAddr.delete();
      logData.delete();
      @(posedge clk);
      applyReset();
      waitForHalt(2000);
      confirm(haltSeen, "halt did not rise within 2000 cycles after the illegal word");
      compareValue("err", 16'(err), 16'h1);
      compareValue("halt", 16'(halt), 16'h1);
      compareValue("store count", 16'(logAddr.size()), 16'h1);
      compareStores(0, 1);
      reportTest("illegal opcode");

      $display("%0d tests: %0d passed, %0d failed", passCount + failCount, passCount, failCount);
      if (failCount == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== testbench/program.hex ====
// one 16-bit instruction word per line, word address 0 first
// fields: op[15:12] rd[11:9] rs[8:6] rt[5:3], or a signed immediate in the low bits
4205  // addi r1, r0, 5
4403  // addi r2, r0, 3
0650  // add  r3, r1, r2
1850  // sub  r4, r1, r2
2A50  // and  r5, r1, r2
3C50  // xor  r6, r1, r2
6610  // st   r3, 16(r0)
6811  // st   r4, 17(r0)
6A12  // st   r5, 18(r0)
6C13  // st   r6, 19(r0)
4E3E  // addi r7, r0, -2
6E14  // st   r7, 20(r0)
5608  // ld   r3, 8(r0)
08C8  // add  r4, r3, r1
6815  // st   r4, 21(r0)
7001  // beqz r0, +1 taken
6216  // st   r1, 22(r0) skipped
7201  // beqz r1, +1 not taken
6417  // st   r2, 23(r0)
8001  // j    +1
6218  // st   r1, 24(r0) skipped
6C19  // st   r6, 25(r0)
F000  // halt
F000
F000
F000
F000
F000

// ==== filelist.f ====
src/procPkg.sv
src/fetch.sv
src/decode.sv
src/execute.sv
src/memAccess.sv
src/proc.sv
testbench/procTb.sv

// ==== Makefile ====
# Verilator build and run of the pipelined processor testbench
# the simulation runs inside testbench/ so that fetch can read program.hex

.PHONY: all lint clean

all: obj_dir/VprocTb
	@out=$$(cd testbench && ../obj_dir/VprocTb); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

obj_dir/VprocTb: filelist.f src/*.sv testbench/procTb.sv
	verilator --binary --timing --assert --top-module procTb -f filelist.f

lint:
	verilator --lint-only -Wall --top-module proc \
		src/procPkg.sv src/fetch.sv src/decode.sv \
		src/execute.sv src/memAccess.sv src/proc.sv

clean:
	rm -rf obj_dir
